//--- project.f
src/btb_geom_pkg.sv
src/btb_pred_pkg.sv
src/pred_if.sv
src/btb_tag_hash.sv
src/bram_1rport_1wport.sv
src/bram_2rport_1wport.sv
src/btb.sv
src/pred_queue.sv
src/redirect_select.sv
src/btb_frontend.sv
test/tb_clock_gen.sv
test/tb_btb_frontend.sv

//--- run.sh
#!/bin/sh
# build the BTB front-end testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_btb_frontend \
    -f project.f \
    -o tb_btb_frontend

# a $fatal in the testbench gives a failing exit status
./obj_dir/tb_btb_frontend

//--- src/bram_1rport_1wport.sv
/*
    One-read, one-write synchronous array
    registered read, byte-enabled write, cleared at reset
    a read and a write to the same row return the old row
*/

`timescale 1ns/1ns

module bram_1rport_1wport #(
    parameter int INNER_WIDTH = 32,
    parameter int OUTER_WIDTH = 64
) (
    input  logic CLK,
    input  logic nRST,

    input  logic                           ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] rindex,
    output logic [INNER_WIDTH-1:0]         rdata,

    input  logic [INNER_WIDTH/8-1:0]       wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem   <= '{default: '0};
            rdata <= '0;
        end else begin
            // data holds while ren is low
            if (ren) begin
                rdata <= mem[rindex];
            end
            for (int b = 0; b < INNER_WIDTH/8; b++) begin
                if (wen_byte[b]) begin
                    mem[windex][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- src/bram_2rport_1wport.sv
/*
    Two-read, one-write synchronous array
    two independent registered read ports, byte-enabled write,
    cleared at reset, old data on a same-row read and write
*/

`timescale 1ns/1ns

module bram_2rport_1wport #(
    parameter int INNER_WIDTH = 16,
    parameter int OUTER_WIDTH = 64
) (
    input  logic CLK,
    input  logic nRST,

    input  logic                           port0_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port0_rindex,
    output logic [INNER_WIDTH-1:0]         port0_rdata,

    input  logic                           port1_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0] port1_rindex,
    output logic [INNER_WIDTH-1:0]         port1_rdata,

    input  logic [INNER_WIDTH/8-1:0]       wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem         <= '{default: '0};
            port0_rdata <= '0;
            port1_rdata <= '0;
        end else begin
            if (port0_ren) begin
                port0_rdata <= mem[port0_rindex];
            end
            // port 1 serves the update read-modify-write
            if (port1_ren) begin
                port1_rdata <= mem[port1_rindex];
            end
            for (int b = 0; b < INNER_WIDTH/8; b++) begin
                if (wen_byte[b]) begin
                    mem[windex][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- src/btb.sv
/*
    Branch target buffer
    2-way set-associative lookup of a 16-slot fetch block,
    result one cycle after acceptance, plus a two-cycle update
    that writes one slot of one way and its LRU bit
*/

`timescale 1ns/1ns

module btb
    import btb_geom_pkg::*, btb_pred_pkg::*;
(
    input  logic CLK,
    input  logic nRST,

    input  logic                           lookup_fire,
    input  logic [31:0]                    lookup_pc,
    input  logic [ASID_WIDTH-1:0]          asid,

    input  logic                           update0_valid,
    input  logic [31:0]                    update0_pc,
    input  logic [BTB_PRED_INFO_WIDTH-1:0] update1_pred_info,
    input  logic                           update1_pred_lru,
    input  logic [31:0]                    update1_target_pc,

    pred_if.source resp
);

    // request stage
    logic [BTB_INDEX_WIDTH-1:0] req_index;
    logic [BTB_TAG_WIDTH-1:0]   req_tag;

    // response stage
    logic                                              resp_valid;
    logic [31:0]                                       resp_pc;
    logic [BTB_TAG_WIDTH-1:0]                          resp_tag;
    logic [BTB_SLOTS-1:0][BTB_ASSOC-1:0][BTB_WAY_BITS-1:0] entry_rdata;
    logic [BTB_SLOTS-1:0]                              lru_rdata;

    // update
    logic [BTB_TAG_WIDTH-1:0]                          upd0_tag;
    logic                                              upd_valid;
    logic [BTB_INDEX_WIDTH-1:0]                        upd_index;
    logic [BTB_SLOT_WIDTH-1:0]                         upd_slot;
    logic [BTB_TAG_WIDTH-1:0]                          upd_tag;
    logic [BTB_SLOTS-1:0]                              lru_old;
    logic [BTB_SLOTS-1:0]                              lru_new;
    logic [BTB_WAY_BITS-1:0]                           upd_word;
    logic [BTB_SLOTS*BTB_ASSOC*BTB_WAY_BYTES-1:0]      entry_wen;

    // ----------------------------------------
    // request stage

    assign req_index = lookup_pc[BTB_INDEX_LSB +: BTB_INDEX_WIDTH];

    btb_tag_hash req_hash (
        .pc   (lookup_pc),
        .asid (asid),
        .tag  (req_tag)
    );

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            resp_valid <= 1'b0;
            upd_valid  <= 1'b0;
        end else begin
            resp_valid <= lookup_fire;
            upd_valid  <= update0_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (lookup_fire) begin
            resp_pc  <= lookup_pc;
            resp_tag <= req_tag;
        end
        if (update0_valid) begin
            upd_index <= update0_pc[BTB_INDEX_LSB +: BTB_INDEX_WIDTH];
            upd_slot  <= update0_pc[BTB_SLOT_LSB +: BTB_SLOT_WIDTH];
            upd_tag   <= upd0_tag;
        end
    end

    // ----------------------------------------
    // response stage

    assign resp.valid    = resp_valid;
    assign resp.start_pc = resp_pc;

    always_comb begin
        for (int i = 0; i < BTB_SLOTS; i++) begin
            // way 0 wins when both ways match
            if (entry_rdata[i][0][BTB_TARGET_WIDTH +: BTB_TAG_WIDTH] == resp_tag) begin
                resp.hit[i] = 1'b1;
                resp.lru[i] = 1'b0;
                resp.info[i] = entry_rdata[i][0][BTB_ENTRY_WIDTH-1 -: BTB_PRED_INFO_WIDTH];
                resp.target[i] = entry_rdata[i][0][BTB_TARGET_WIDTH-1:0];
            end else if (entry_rdata[i][1][BTB_TARGET_WIDTH +: BTB_TAG_WIDTH] == resp_tag) begin
                resp.hit[i] = 1'b1;
                resp.lru[i] = 1'b1;
                resp.info[i] = entry_rdata[i][1][BTB_ENTRY_WIDTH-1 -: BTB_PRED_INFO_WIDTH];
                resp.target[i] = entry_rdata[i][1][BTB_TARGET_WIDTH-1:0];
            end else begin
                // miss reports the stored LRU bit
                resp.hit[i] = 1'b0;
                resp.lru[i] = lru_rdata[i];
                resp.info[i] = entry_rdata[i][0][BTB_ENTRY_WIDTH-1 -: BTB_PRED_INFO_WIDTH];
                resp.target[i] = entry_rdata[i][0][BTB_TARGET_WIDTH-1:0];
            end
        end
    end

    // ----------------------------------------
    // update, second cycle writes

    btb_tag_hash upd_hash (
        .pc   (update0_pc),
        .asid (asid),
        .tag  (upd0_tag)
    );

    assign upd_word = {{(BTB_WAY_BITS-BTB_ENTRY_WIDTH){1'b0}}, update1_pred_info, upd_tag,
                       update1_target_pc[BTB_TARGET_WIDTH:1]};

    always_comb begin
        lru_new = lru_old;
        lru_new[upd_slot] = update1_pred_lru;
        // only the chosen way of the chosen slot
        entry_wen = '0;
        if (upd_valid) begin
            entry_wen[(int'(upd_slot)*BTB_ASSOC + int'(update1_pred_lru))*BTB_WAY_BYTES
                      +: BTB_WAY_BYTES] = '1;
        end
    end

    bram_1rport_1wport #(
        .INNER_WIDTH (BTB_SLOTS*BTB_ASSOC*BTB_WAY_BITS),
        .OUTER_WIDTH (BTB_SETS)
    ) entry_array (
        .CLK      (CLK),
        .nRST     (nRST),
        .ren      (lookup_fire),
        .rindex   (req_index),
        .rdata    (entry_rdata),
        .wen_byte (entry_wen),
        .windex   (upd_index),
        .wdata    ({(BTB_SLOTS*BTB_ASSOC){upd_word}})
    );

    bram_2rport_1wport #(
        .INNER_WIDTH (BTB_SLOTS),
        .OUTER_WIDTH (BTB_SETS)
    ) lru_array (
        .CLK          (CLK),
        .nRST         (nRST),
        .port0_ren    (lookup_fire),
        .port0_rindex (req_index),
        .port0_rdata  (lru_rdata),
        .port1_ren    (update0_valid),
        .port1_rindex (update0_pc[BTB_INDEX_LSB +: BTB_INDEX_WIDTH]),
        .port1_rdata  (lru_old),
        .wen_byte     ({(BTB_SLOTS/8){upd_valid}}),
        .windex       (upd_index),
        .wdata        (lru_new)
    );

endmodule

//--- src/btb_frontend.sv
/*
    BTB front end
    lookup buffer, result queue and redirect selector
    behind plain ports
*/

`timescale 1ns/1ns

module btb_frontend
    import btb_geom_pkg::*, btb_pred_pkg::*;
(
    input  logic CLK,
    input  logic nRST,

    input  logic                           lookup_valid,
    output logic                           lookup_ready,
    input  logic [31:0]                    lookup_pc,
    input  logic [ASID_WIDTH-1:0]          asid,

    input  logic                           update0_valid,
    input  logic [31:0]                    update0_pc,
    input  logic [BTB_PRED_INFO_WIDTH-1:0] update1_pred_info,
    input  logic                           update1_pred_lru,
    input  logic [31:0]                    update1_target_pc,

    output logic                           pred_req,
    input  logic                           pred_ack,
    output logic                           pred_taken,
    output logic [BTB_SLOT_WIDTH-1:0]      pred_slot,
    output logic [BTB_PRED_INFO_WIDTH-1:0] pred_info,
    output logic                           pred_lru,
    output logic [31:0]                    pred_next_pc
);

    logic lookup_fire;
    logic pop;

    pred_if btb_res ();
    pred_if q_out ();

    assign lookup_fire = lookup_valid && lookup_ready;

    btb u_btb (
        .CLK               (CLK),
        .nRST              (nRST),
        .lookup_fire       (lookup_fire),
        .lookup_pc         (lookup_pc),
        .asid              (asid),
        .update0_valid     (update0_valid),
        .update0_pc        (update0_pc),
        .update1_pred_info (update1_pred_info),
        .update1_pred_lru  (update1_pred_lru),
        .update1_target_pc (update1_target_pc),
        .resp              (btb_res.source)
    );

    // the registered lookup_fire is the BTB result valid
    pred_queue u_queue (
        .CLK              (CLK),
        .nRST             (nRST),
        .in_valid_pending (btb_res.valid),
        .enq              (btb_res.sink),
        .deq              (q_out.source),
        .pop              (pop),
        .ready            (lookup_ready)
    );

    redirect_select u_select (
        .CLK          (CLK),
        .nRST         (nRST),
        .deq          (q_out.sink),
        .pop          (pop),
        .pred_req     (pred_req),
        .pred_ack     (pred_ack),
        .pred_taken   (pred_taken),
        .pred_slot    (pred_slot),
        .pred_info    (pred_info),
        .pred_lru     (pred_lru),
        .pred_next_pc (pred_next_pc)
    );

endmodule

//--- src/btb_geom_pkg.sv
/*
    BTB geometry
    set-associative array shape and the PC fields that index it
*/

package btb_geom_pkg;

    // fetch block of 16 two-byte slots
    localparam int BTB_SLOTS       = 16;
    localparam int BTB_BLOCK_BYTES = 32;
    localparam int BTB_ASSOC       = 2;
    localparam int BTB_SETS        = 64;

    // PC[10:5] set index, PC[4:1] slot
    localparam int BTB_INDEX_WIDTH = 6;
    localparam int BTB_INDEX_LSB   = 5;
    localparam int BTB_SLOT_WIDTH  = 4;
    localparam int BTB_SLOT_LSB    = 1;

    // hashed tag built from PC[31:11] and the ASID
    localparam int BTB_TAG_WIDTH   = 8;
    localparam int BTB_TAG_LSB     = 11;
    localparam int BTB_TAG_CHUNKS  = 3;
    localparam int ASID_WIDTH      = 8;

endpackage

//--- src/btb_pred_pkg.sv
/*
    BTB prediction encoding
    entry fields, stored word layout, result queue and redirect FSM
*/

package btb_pred_pkg;

    import btb_geom_pkg::*;

    // bit 7 is taken, the rest is opaque payload
    localparam int BTB_PRED_INFO_WIDTH = 8;
    localparam int BTB_TAKEN_BIT       = 7;

    // target holds PC[12:1]
    localparam int BTB_TARGET_WIDTH    = 12;

    // one way: {pad, info, tag, target}, padded to whole bytes
    localparam int BTB_ENTRY_WIDTH = BTB_PRED_INFO_WIDTH + BTB_TAG_WIDTH + BTB_TARGET_WIDTH;
    localparam int BTB_WAY_BYTES   = 4;
    localparam int BTB_WAY_BITS    = BTB_WAY_BYTES * 8;

    localparam int PRED_QUEUE_DEPTH     = 4;
    localparam int PRED_QUEUE_PTR_WIDTH = $clog2(PRED_QUEUE_DEPTH);

    // redirect FSM states
    localparam logic [1:0] RS_IDLE    = 2'd0;
    localparam logic [1:0] RS_REQ     = 2'd1;
    localparam logic [1:0] RS_ACK_LOW = 2'd2;

endpackage

//--- src/btb_tag_hash.sv
/*
    BTB tag hash
    XOR-folds PC[31:11] in 8-bit chunks together with the ASID
*/

`timescale 1ns/1ns

module btb_tag_hash
    import btb_geom_pkg::*;
(
    input  logic [31:0]              pc,
    input  logic [ASID_WIDTH-1:0]    asid,
    output logic [BTB_TAG_WIDTH-1:0] tag
);

    logic [BTB_TAG_CHUNKS*BTB_TAG_WIDTH-1:0] upper;

    // top chunk is zero-padded
    assign upper = {{(BTB_TAG_CHUNKS*BTB_TAG_WIDTH-(32-BTB_TAG_LSB)){1'b0}},
                    pc[31:BTB_TAG_LSB]};

    always_comb begin
        tag = asid;
        for (int i = 0; i < BTB_TAG_CHUNKS; i++) begin
            tag = tag ^ upper[i*BTB_TAG_WIDTH +: BTB_TAG_WIDTH];
        end
    end

endmodule

//--- src/pred_if.sv
/*
    Lookup result bundle
    per-slot hit, prediction info, LRU way and partial target
    for one fetch block, plus its start PC
*/

`timescale 1ns/1ns

interface pred_if
    import btb_geom_pkg::*, btb_pred_pkg::*;
();

    logic                                          valid;
    logic [31:0]                                   start_pc;
    logic [BTB_SLOTS-1:0]                          hit;
    logic [BTB_SLOTS-1:0][BTB_PRED_INFO_WIDTH-1:0] info;
    logic [BTB_SLOTS-1:0]                          lru;
    logic [BTB_SLOTS-1:0][BTB_TARGET_WIDTH-1:0]    target;

    modport source (output valid, start_pc, hit, info, lru, target);
    modport sink   (input  valid, start_pc, hit, info, lru, target);

endinterface

//--- src/pred_queue.sv
/*
    Lookup result queue
    small FIFO between the BTB and the redirect selector;
    ready also counts results still in flight in the BTB
*/

`timescale 1ns/1ns

module pred_queue
    import btb_geom_pkg::*, btb_pred_pkg::*;
(
    input  logic CLK,
    input  logic nRST,

    input  logic   in_valid_pending,
    pred_if.sink   enq,
    pred_if.source deq,
    input  logic   pop,
    output logic   ready
);

    logic [31:0]                                   pc_mem     [PRED_QUEUE_DEPTH];
    logic [BTB_SLOTS-1:0]                          hit_mem    [PRED_QUEUE_DEPTH];
    logic [BTB_SLOTS-1:0][BTB_PRED_INFO_WIDTH-1:0] info_mem   [PRED_QUEUE_DEPTH];
    logic [BTB_SLOTS-1:0]                          lru_mem    [PRED_QUEUE_DEPTH];
    logic [BTB_SLOTS-1:0][BTB_TARGET_WIDTH-1:0]    target_mem [PRED_QUEUE_DEPTH];

    logic [PRED_QUEUE_PTR_WIDTH-1:0] wptr;
    logic [PRED_QUEUE_PTR_WIDTH-1:0] rptr;
    logic [PRED_QUEUE_PTR_WIDTH:0]   count;
    logic                            do_pop;

    assign do_pop = pop && (count != '0);

    // free entries minus results the BTB has yet to deliver
    assign ready = (count + {{PRED_QUEUE_PTR_WIDTH{1'b0}}, in_valid_pending})
                   < (PRED_QUEUE_PTR_WIDTH+1)'(PRED_QUEUE_DEPTH);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (enq.valid) begin
                wptr <= wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= rptr + 1'b1;
            end
            count <= count + {{PRED_QUEUE_PTR_WIDTH{1'b0}}, enq.valid}
                           - {{PRED_QUEUE_PTR_WIDTH{1'b0}}, do_pop};
        end
    end

    always_ff @(posedge CLK) begin
        if (enq.valid) begin
            pc_mem[wptr]     <= enq.start_pc;
            hit_mem[wptr]    <= enq.hit;
            info_mem[wptr]   <= enq.info;
            lru_mem[wptr]    <= enq.lru;
            target_mem[wptr] <= enq.target;
        end
    end

    assign deq.valid    = (count != '0);
    assign deq.start_pc = pc_mem[rptr];
    assign deq.hit      = hit_mem[rptr];
    assign deq.info     = info_mem[rptr];
    assign deq.lru      = lru_mem[rptr];
    assign deq.target   = target_mem[rptr];

endmodule

//--- src/redirect_select.sv
/*
    Redirect selector
    picks the first taken hit at or after the start slot
    and offers the next fetch PC on a four-phase req/ack
*/

`timescale 1ns/1ns

module redirect_select
    import btb_geom_pkg::*, btb_pred_pkg::*;
(
    input  logic CLK,
    input  logic nRST,

    pred_if.sink deq,
    output logic pop,

    output logic                           pred_req,
    input  logic                           pred_ack,
    output logic                           pred_taken,
    output logic [BTB_SLOT_WIDTH-1:0]      pred_slot,
    output logic [BTB_PRED_INFO_WIDTH-1:0] pred_info,
    output logic                           pred_lru,
    output logic [31:0]                    pred_next_pc
);

    logic [1:0]                state;
    logic [1:0]                state_next;
    logic [BTB_SLOT_WIDTH-1:0] start_slot;
    logic [BTB_SLOT_WIDTH-1:0] sel;
    logic                      found;

    assign start_slot = deq.start_pc[BTB_SLOT_LSB +: BTB_SLOT_WIDTH];

    // scan downward so the lowest qualifying slot is kept
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int i = BTB_SLOTS-1; i >= 0; i--) begin
            if (i >= int'(start_slot) && deq.hit[i] && deq.info[i][BTB_TAKEN_BIT]) begin
                found = 1'b1;
                sel   = BTB_SLOT_WIDTH'(i);
            end
        end
    end

    assign pop      = (state == RS_IDLE) && deq.valid;
    assign pred_req = (state == RS_REQ);

    // ----------------------------------------
    // handshake FSM

    always_comb begin
        state_next = state;
        case (state)
            RS_IDLE:    if (deq.valid) state_next = RS_REQ;
            RS_REQ:     if (pred_ack) state_next = RS_ACK_LOW;
            RS_ACK_LOW: if (!pred_ack) state_next = RS_IDLE;
            default:    state_next = RS_IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= RS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // outputs stay put until the next pop
    always_ff @(posedge CLK) begin
        if (pop) begin
            pred_taken <= found;
            pred_slot  <= sel;
            pred_info  <= deq.info[sel];
            pred_lru   <= deq.lru[sel];
            if (found) begin
                pred_next_pc <= {deq.start_pc[31:BTB_TARGET_WIDTH+1], deq.target[sel], 1'b0};
            end else begin
                pred_next_pc <= (deq.start_pc & ~32'(BTB_BLOCK_BYTES-1))
                                + 32'(BTB_BLOCK_BYTES);
            end
        end
    end

endmodule

//--- test/tb_btb_frontend.sv
/*
    BTB front-end testbench
    trains entries through the update port, issues lookups, and
    checks every redirect against a shadow model of the arrays;
    a random-delay responder closes the four-phase handshake
*/

`timescale 1ns/1ns

module tb_btb_frontend
    import btb_geom_pkg::*, btb_pred_pkg::*;
();

    localparam int          CLK_PERIOD = 8;
    localparam int          NUM_OPS    = 40;
    localparam logic [31:0] SEED       = 32'hd18a;

    typedef struct packed {
        logic        taken;
        logic [3:0]  slot;
        logic [7:0]  info;
        logic        lru;
        logic [31:0] next_pc;
    } redirect_t;

    logic        CLK;
    logic        nRST;
    logic        lookup_valid;
    logic        lookup_ready;
    logic [31:0] lookup_pc;
    logic [7:0]  asid;
    logic        update0_valid;
    logic [31:0] update0_pc;
    logic [7:0]  update1_pred_info;
    logic        update1_pred_lru;
    logic [31:0] update1_target_pc;
    logic        pred_req;
    logic        pred_ack;
    logic        pred_taken;
    logic [3:0]  pred_slot;
    logic [7:0]  pred_info;
    logic        pred_lru;
    logic [31:0] pred_next_pc;

    // shadow of the entry and LRU arrays
    logic [7:0]  m_tag    [BTB_SETS][BTB_ASSOC][BTB_SLOTS];
    logic [7:0]  m_info   [BTB_SETS][BTB_ASSOC][BTB_SLOTS];
    logic [11:0] m_target [BTB_SETS][BTB_ASSOC][BTB_SLOTS];
    logic        m_lru    [BTB_SETS][BTB_SLOTS];

    redirect_t   expect_q [$];
    logic [31:0] rng_state   = SEED;
    logic        saw_stall   = 1'b0;
    logic        req_seen    = 1'b0;

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) clock_gen (.CLK(CLK), .nRST(nRST));

    btb_frontend UUT (.*);

    // ----------------------------------------
    // random numbers and reference model

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    // PC[31:11] as three 8-bit chunks with the top one zero-padded
    function automatic logic [7:0] fold_tag(input logic [31:0] pc, input logic [7:0] id);
        return id ^ pc[18:11] ^ pc[26:19] ^ {3'b000, pc[31:27]};
    endfunction

    task automatic random_pc(input logic [7:0] id, output logic [31:0] pc);
        logic [31:0] r;
        // zero tags would match the cleared arrays
        do begin
            next_rand(r);
        end while (fold_tag({r[31:1], 1'b0}, id) == 8'h00);
        pc = {r[31:1], 1'b0};
    endtask

    task automatic clear_model();
        for (int s = 0; s < BTB_SETS; s++) begin
            for (int k = 0; k < BTB_SLOTS; k++) begin
                m_lru[s][k] = 1'b0;
                for (int w = 0; w < BTB_ASSOC; w++) begin
                    m_tag[s][w][k]    = '0;
                    m_info[s][w][k]   = '0;
                    m_target[s][w][k] = '0;
                end
            end
        end
    endtask

    function automatic redirect_t expect_redirect(input logic [31:0] pc, input logic [7:0] id);
        redirect_t   r;
        logic [5:0]  set;
        logic [3:0]  start;
        logic [7:0]  tag;
        logic        found;
        logic        hit_v  [BTB_SLOTS];
        logic        lru_v  [BTB_SLOTS];
        logic [7:0]  info_v [BTB_SLOTS];
        logic [11:0] tgt_v  [BTB_SLOTS];
        set   = pc[10:5];
        start = pc[4:1];
        tag   = fold_tag(pc, id);
        for (int s = 0; s < BTB_SLOTS; s++) begin
            // way 0 wins over way 1
            // a miss shows way 0 data and the stored LRU
            if (m_tag[set][0][s] == tag) begin
                hit_v[s] = 1'b1;
                lru_v[s] = 1'b0;
            end else if (m_tag[set][1][s] == tag) begin
                hit_v[s] = 1'b1;
                lru_v[s] = 1'b1;
            end else begin
                hit_v[s] = 1'b0;
                lru_v[s] = m_lru[set][s];
            end
            info_v[s] = m_info[set][hit_v[s] ? lru_v[s] : 1'b0][s];
            tgt_v[s]  = m_target[set][hit_v[s] ? lru_v[s] : 1'b0][s];
        end
        found     = 1'b0;
        r.taken   = 1'b0;
        r.slot    = '0;
        r.info    = info_v[0];
        r.lru     = lru_v[0];
        r.next_pc = {pc[31:5], 5'b00000} + 32'd32;
        for (int s = 0; s < BTB_SLOTS; s++) begin
            if (!found && s >= int'(start) && hit_v[s] && info_v[s][7]) begin
                found     = 1'b1;
                r.taken   = 1'b1;
                r.slot    = 4'(s);
                r.info    = info_v[s];
                r.lru     = lru_v[s];
                r.next_pc = {pc[31:13], tgt_v[s], 1'b0};
            end
        end
        return r;
    endfunction

    // ----------------------------------------
    // failure reporting and checks

    task automatic stop_on_failure();
        $display("TB FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic confirm(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            stop_on_failure();
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error %s expected 0x%h got 0x%h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_result();
        redirect_t e;
        if (expect_q.size() == 0) begin
            $display("pred_req rose with no lookup outstanding");
            stop_on_failure();
        end else begin
            e = expect_q.pop_front();
            compare_field("pred_taken", 32'(e.taken), 32'(pred_taken));
            compare_field("pred_slot", 32'(e.slot), 32'(pred_slot));
            compare_field("pred_info", 32'(e.info), 32'(pred_info));
            compare_field("pred_lru", 32'(e.lru), 32'(pred_lru));
            compare_field("pred_next_pc", e.next_pc, pred_next_pc);
        end
    endtask

    // outputs are stable for the whole request phase
    always @(posedge CLK) begin
        if (nRST && pred_req && !req_seen) begin
            check_result();
        end
        req_seen = pred_req;
    end

    // ack 1 to 5 cycles after pred_req and drop it once pred_req falls
    initial begin : ack_responder
        logic [31:0] ack_rng;
        ack_rng  = SEED;
        pred_ack = 1'b0;
        forever begin
            @(posedge CLK);
            if (pred_req && !pred_ack) begin
                ack_rng = xorshift32(ack_rng);
                repeat (ack_rng % 5) @(posedge CLK);
                pred_ack <= 1'b1;
                do @(posedge CLK); while (pred_req);
                pred_ack <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(NUM_OPS * 40 * CLK_PERIOD);
        $display("timeout: the tests did not finish in time");
        stop_on_failure();
    end

    // ----------------------------------------
    // stimulus tasks run just after a rising edge

    task automatic issue_lookup(input logic [31:0] pc, input logic [7:0] id,
                                output redirect_t e);
        lookup_valid <= 1'b1;
        lookup_pc    <= pc;
        asid         <= id;
        @(posedge CLK);
        while (!lookup_ready) begin
            saw_stall = 1'b1;
            @(posedge CLK);
        end
        e = expect_redirect(pc, id);
        expect_q.push_back(e);
    endtask

    task automatic end_lookups();
        lookup_valid <= 1'b0;
    endtask

    task automatic write_entry(input logic [31:0] pc, input logic [7:0] id,
                               input logic [7:0] info, input logic lru,
                               input logic [31:0] target);
        update0_valid <= 1'b1;
        update0_pc    <= pc;
        asid          <= id;
        @(posedge CLK);
        update0_valid     <= 1'b0;
        update1_pred_info <= info;
        update1_pred_lru  <= lru;
        update1_target_pc <= target;
        // written at the edge that closes the second cycle
        @(posedge CLK);
        m_tag[pc[10:5]][lru][pc[4:1]]    = fold_tag(pc, id);
        m_info[pc[10:5]][lru][pc[4:1]]   = info;
        m_target[pc[10:5]][lru][pc[4:1]] = target[12:1];
        m_lru[pc[10:5]][pc[4:1]]         = lru;
    endtask

    task automatic wait_drain();
        while (expect_q.size() != 0 || pred_req || pred_ack) begin
            @(posedge CLK);
        end
    endtask

    // ----------------------------------------
    // test sequence

    initial begin : stimulus
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        logic [31:0] r;
        logic [7:0]  id;
        logic [3:0]  s_lo;
        logic [3:0]  s_hi;
        redirect_t   e;
        lookup_valid      = 1'b0;
        lookup_pc         = '0;
        asid              = '0;
        update0_valid     = 1'b0;
        update0_pc        = '0;
        update1_pred_info = '0;
        update1_pred_lru  = 1'b0;
        update1_target_pc = '0;
        clear_model();
        wait (nRST === 1'b1);
        @(posedge CLK);

        // every block falls through on the cleared arrays
        repeat (8) begin
            next_rand(r);
            random_pc(r[7:0], pc_a);
            issue_lookup(pc_a, r[7:0], e);
            confirm(!e.taken, "model predicts taken right after reset");
        end
        end_lookups();
        wait_drain();

        // one taken entry, then the same block under another ASID
        next_rand(r);
        id = r[7:0];
        random_pc(id, pc_a);
        next_rand(r);
        write_entry(pc_a, id, {1'b1, r[6:0]}, r[7], r);
        issue_lookup({pc_a[31:5], 5'b00000}, id, e);
        confirm(e.taken && e.slot == pc_a[4:1], "trained slot is not the expected pick");
        issue_lookup({pc_a[31:5], 5'b00000}, id ^ 8'h5c, e);
        confirm(!e.taken, "other ASID expected to miss");
        end_lookups();
        wait_drain();

        // two taken slots where the start slot decides
        next_rand(r);
        id   = r[15:8];
        s_lo = 4'(r[3:0] % 7);
        s_hi = s_lo + 4'd1 + 4'(r[7:4] % 7);
        random_pc(id, pc_a);
        next_rand(r);
        write_entry({pc_a[31:5], s_lo, 1'b0}, id, {1'b1, r[6:0]}, r[8], r);
        next_rand(r);
        write_entry({pc_a[31:5], s_hi, 1'b0}, id, {1'b1, r[6:0]}, r[8], r);
        issue_lookup({pc_a[31:5], 5'b00000}, id, e);
        confirm(e.taken && e.slot == s_lo, "lowest taken slot not chosen");
        issue_lookup({pc_a[31:5], s_lo + 4'd1, 1'b0}, id, e);
        confirm(e.taken && e.slot == s_hi, "slot below the start not skipped");
        issue_lookup({pc_a[31:5], s_hi, 1'b0}, id, e);
        confirm(e.taken && e.slot == s_hi, "start slot itself not chosen");
        issue_lookup({pc_a[31:5], s_hi + 4'd1, 1'b0}, id, e);
        confirm(!e.taken, "taken slots below the start still chosen");
        end_lookups();
        wait_drain();

        // both ways of one slot, then way 0 replaced
        next_rand(r);
        id = r[7:0];
        random_pc(id, pc_a);
        pc_b = pc_a ^ 32'h0000_0800;
        next_rand(r);
        write_entry(pc_a, id, {1'b1, r[6:0]}, 1'b0, r);
        next_rand(r);
        write_entry(pc_b, id, {1'b1, r[6:0]}, 1'b1, r);
        issue_lookup(pc_a, id, e);
        confirm(e.taken && !e.lru, "way 0 entry not visible");
        issue_lookup(pc_b, id, e);
        confirm(e.taken && e.lru, "way 1 entry not visible");
        end_lookups();
        next_rand(r);
        write_entry(pc_a ^ 32'h0000_1000, id, {1'b1, r[6:0]}, 1'b0, r);
        issue_lookup(pc_a, id, e);
        confirm(!e.taken, "replaced way 0 entry still expected");
        issue_lookup(pc_b, id, e);
        confirm(e.taken && e.lru, "way 1 entry lost by the replacement");
        end_lookups();
        wait_drain();

        // back-to-back lookups against slow acks
        saw_stall = 1'b0;
        for (int n = 0; n < 16; n++) begin
            if (n % 4 == 0) begin
                issue_lookup(pc_b, id, e);
            end else begin
                next_rand(r);
                random_pc(r[7:0], pc_a);
                issue_lookup(pc_a, r[7:0], e);
            end
        end
        end_lookups();
        wait_drain();
        confirm(saw_stall, "lookup_ready never fell with the queue full");

        repeat (4) @(posedge CLK);
        confirm(lookup_ready, "lookup_ready still low after every result was delivered");
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
/*
    Testbench clock and reset
    free-running clock, reset held low for two rising edges
*/

`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD/2) CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule
